//--- Bender.yml
package:
  name: alu_top

sources:
  - design/alu_pkg.sv
  - design/alu_unit_if.sv
  - design/add_sub_unit.sv
  - design/magnitude_comparator.sv
  - design/barrel_shifter.sv
  - design/logic_unit.sv
  - design/result_select.sv
  - design/alu_top.sv
  - target: simulation
    files:
      - tb/tb_alu_top.sv

//--- design/add_sub_unit.sv
/*
 * Adder and subtractor. Two ripple-carry chains built from full-adder
 * slices, one for A+B and one for A-B as A + ~B + 1.
 */
`timescale 1ns/100ps

module add_sub_unit #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    alu_unit_if.arith             units
);

    // Chain 0 adds, chain 1 subtracts.
    logic [1:0][data_width-1:0] operand;
    logic [1:0][data_width-1:0] carry;
    logic [1:0][data_width-1:0] total;

    assign operand[0] = b;
    assign operand[1] = ~b;     // Inverted B for subtraction.
    assign carry[0][0] = 1'b0;
    assign carry[1][0] = 1'b1;  // The +1 of the two's complement.

    for (genvar j = 0; j < 2; j++) begin : g_chain
        for (genvar i = 0; i < data_width; i++) begin : g_slice
            assign total[j][i] = a[i] ^ operand[j][i] ^ carry[j][i];

            // The top slice has no carry-out.
            if (i < data_width - 1) begin : g_carry
                assign carry[j][i+1] = (a[i] & operand[j][i])
                                     | ((a[i] ^ operand[j][i]) & carry[j][i]);
            end
        end
    end

    assign units.sum  = total[0];
    assign units.diff = total[1];

endmodule

//--- design/alu_pkg.sv
/*
 * ALU package. Default operand width and the operation codes
 * of the execute-stage ALU, encoded as the decode stage issues them.
 */
package alu_pkg;

    // ####################
    // Widths
    // ####################

    localparam int DATA_WIDTH = 32; // Operand and result width.

    // ####################
    // Operation codes
    // ####################

    // All sixteen codes are in use, so every value of the field is legal.
    // Bit 3 marks the right shifts and the branch compares.
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SUB  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        BEQ  = 4'b1000,
        SRL  = 4'b1001,
        BLT  = 4'b1010,
        BLTU = 4'b1011,
        BNE  = 4'b1100,
        SRA  = 4'b1101,
        BGE  = 4'b1110,
        BGEU = 4'b1111
    } alu_op_e;

endpackage

//--- design/alu_top.sv
/*
 * Execute-stage ALU top level. Connects the function units
 * to result selection through the unit result bundle.
 */
`timescale 1ns/100ps

module alu_top #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] data_a,
    input  logic [data_width-1:0] data_b,
    input  alu_pkg::alu_op_e      alu_op,
    output logic [data_width-1:0] result,
    output logic                  zero
);

    alu_unit_if #(.data_width(data_width)) units ();

    add_sub_unit #(.data_width(data_width)) add_sub_i (
        .a     (data_a),
        .b     (data_b),
        .units (units)
    );

    magnitude_comparator #(.data_width(data_width)) compare_i (
        .a     (data_a),
        .b     (data_b),
        .units (units)
    );

    barrel_shifter #(.data_width(data_width)) shifter_i (
        .a      (data_a),
        .b      (data_b),
        .alu_op (alu_op),
        .units  (units)
    );

    logic_unit #(.data_width(data_width)) logic_i (
        .a      (data_a),
        .b      (data_b),
        .alu_op (alu_op),
        .units  (units)
    );

    result_select #(.data_width(data_width)) select_i (
        .a      (data_a),
        .b      (data_b),
        .alu_op (alu_op),
        .units  (units),
        .result (result),
        .zero   (zero)
    );

endmodule

//--- design/alu_unit_if.sv
/*
 * Function unit results on their way to result selection.
 * Each unit drives its own modport and the selector reads them all.
 */
`timescale 1ns/100ps

interface alu_unit_if #(
    parameter int data_width = alu_pkg::DATA_WIDTH
);

    typedef logic [data_width-1:0] word_t;

    word_t sum;       // A + B.
    word_t diff;      // A - B.
    logic  eq;        // A == B.
    logic  lt_u;      // A < B, unsigned.
    word_t shifted;
    word_t logic_out;

    modport arith (output sum, output diff);
    modport compare (output eq, output lt_u);
    modport shift (output shifted);
    modport logical (output logic_out);

    modport select (
        input sum,
        input diff,
        input eq,
        input lt_u,
        input shifted,
        input logic_out
    );

endinterface

//--- design/barrel_shifter.sv
/*
 * Logarithmic shifter for SLL, SRL and SRA. A left shift runs through
 * the same right-shift stages on the bit-reversed operand.
 */
`timescale 1ns/100ps

module barrel_shifter #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_pkg::alu_op_e      alu_op,
    alu_unit_if.shift             units
);

    import alu_pkg::*;

    localparam int shamt_width = $clog2(data_width);

    typedef logic [shamt_width-1:0] shamt_t;

    shamt_t                               shamt;
    logic                                 shift_left;
    logic                                 fill;
    logic [data_width-1:0]                a_rev;
    logic [data_width-1:0]                out_rev;
    logic [shamt_width:0][data_width-1:0] stage;

    assign shamt      = b[shamt_width-1:0];  // Upper bits of B are ignored.
    assign shift_left = (alu_op == SLL);
    assign fill       = (alu_op == SRA) & a[data_width-1]; // Sign fill only for SRA.

    // ####################
    // Bit reversal
    // ####################

    for (genvar i = 0; i < data_width; i++) begin : g_rev
        assign a_rev[i]   = a[data_width-1-i];
        assign out_rev[i] = stage[shamt_width][data_width-1-i];
    end

    assign stage[0] = shift_left ? a_rev : a;

    // ####################
    // Shift stages
    // ####################

    for (genvar s = 0; s < shamt_width; s++) begin : g_stage
        localparam int step = 2 ** s;

        assign stage[s+1] = shamt[s]
                          ? {{step{fill}}, stage[s][data_width-1:step]}
                          : stage[s];
    end

    assign units.shifted = shift_left ? out_rev : stage[shamt_width];

endmodule

//--- design/logic_unit.sv
/*
 * Bitwise unit. XOR, OR or AND, picked by the two low operation bits.
 */
`timescale 1ns/100ps

module logic_unit #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_pkg::alu_op_e      alu_op,
    alu_unit_if.logical           units
);

    // XOR 0100, OR 0110, AND 0111. Other codes land on XOR and are
    // discarded by result selection.
    always_comb begin
        case (alu_op[1:0])
            2'b10:   units.logic_out = a | b;
            2'b11:   units.logic_out = a & b;
            default: units.logic_out = a ^ b;
        endcase
    end

endmodule

//--- design/magnitude_comparator.sv
/*
 * Unsigned magnitude comparator. Scans from the MSB so the first
 * differing bit decides less-than; equality is the AND of all bits.
 */
`timescale 1ns/100ps

module magnitude_comparator #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    alu_unit_if.compare           units
);

    logic [data_width-1:0] bit_eq;
    logic [data_width-1:0] bit_lt;
    logic [data_width-1:0] above_eq; // All bits above this one are equal.
    logic [data_width-1:0] decides;

    assign bit_eq = ~(a ^ b);
    assign bit_lt = ~a & b;     // A has 0 where B has 1.

    assign above_eq[data_width-1] = 1'b1;

    for (genvar i = 0; i < data_width - 1; i++) begin : g_prefix
        assign above_eq[i] = above_eq[i+1] & bit_eq[i+1];
    end

    // At most one bit can be the first difference.
    assign decides = above_eq & bit_lt;

    assign units.lt_u = |decides;
    assign units.eq   = &bit_eq;

endmodule

//--- design/result_select.sv
/*
 * Result selection. Picks the unit output for the operation, forms
 * SLT/SLTU, and drives zero as branch decision or result-is-zero.
 */
`timescale 1ns/100ps

module result_select #(
    parameter int data_width = alu_pkg::DATA_WIDTH
) (
    input  logic [data_width-1:0] a,
    input  logic [data_width-1:0] b,
    input  alu_pkg::alu_op_e      alu_op,
    alu_unit_if.select            units,
    output logic [data_width-1:0] result,
    output logic                  zero
);

    import alu_pkg::*;

    localparam int msb = data_width - 1;

    logic signs_differ;
    logic slt_bit;
    logic lt_s;

    // ####################
    // Signed compares
    // ####################

    assign signs_differ = a[msb] ^ b[msb];

    // With mixed signs the negative operand is smaller.
    // Same signs cannot overflow, so the sign of A-B is valid.
    assign slt_bit = signs_differ ? a[msb] : units.diff[msb];

    // Same signs compare like unsigned values.
    assign lt_s = signs_differ ? a[msb] : units.lt_u;

    // ####################
    // Data output
    // ####################

    always_comb begin
        case (alu_op)
            ADD:           result = units.sum;
            SUB:           result = units.diff;
            SLL, SRL, SRA: result = units.shifted;
            XOR, OR, AND:  result = units.logic_out;
            SLT:           result = {{msb{1'b0}}, slt_bit};
            SLTU:          result = {{msb{1'b0}}, units.lt_u};
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                result = units.diff;  // Branches expose A-B.
            end
            default:       result = '0;
        endcase
    end

    // ####################
    // Zero / branch flag
    // ####################

    always_comb begin
        case (alu_op)
            BEQ:     zero = units.eq;
            BNE:     zero = ~units.eq;
            BLT:     zero = lt_s;
            BGE:     zero = ~lt_s;
            BLTU:    zero = units.lt_u;
            BGEU:    zero = ~units.lt_u;
            default: zero = ~|result;   // Result is all zeros.
        endcase
    end

endmodule

//--- sources.f
design/alu_pkg.sv
design/alu_unit_if.sv
design/add_sub_unit.sv
design/magnitude_comparator.sv
design/barrel_shifter.sv
design/logic_unit.sv
design/result_select.sv
design/alu_top.sv
tb/tb_alu_top.sv

//--- tb/tb_alu_top.sv
/*
 * Testbench for the execute-stage ALU. Drives directed and random
 * vectors; concurrent assertions compare against a reference model.
 */
`timescale 1ns/100ps

module tb_alu_top;

    import alu_pkg::*;

    localparam int width       = DATA_WIDTH;
    localparam int shamt_width = $clog2(width);
    localparam int max_cycles  = 600;  // About 400 vectors, reset and margin.

    typedef logic [width-1:0] word_t;

    localparam word_t min_neg  = {1'b1, {(width-1){1'b0}}};
    localparam word_t max_pos  = ~min_neg;
    localparam word_t all_ones = '1;
    localparam word_t one      = word_t'(1);

    logic    clk = 1'b0;
    logic    rst;
    word_t   data_a;
    word_t   data_b;
    alu_op_e alu_op;
    word_t   result;
    logic    zero;
    int      cycle_count = 0;

    alu_top #(.data_width(width)) dut_i (
        .data_a (data_a),
        .data_b (data_b),
        .alu_op (alu_op),
        .result (result),
        .zero   (zero)
    );

    always #4 clk = ~clk;  // 8 ns period.

    // ####################
    // Reference model
    // ####################

    function automatic logic is_branch(alu_op_e op);
        return op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};
    endfunction

    function automatic word_t model_result(word_t a, word_t b, alu_op_e op);
        logic [shamt_width-1:0] shamt;
        shamt = b[shamt_width-1:0];
        case (op)
            ADD:  return a + b;
            SLL:  return a << shamt;
            SRL:  return a >> shamt;
            SRA:  return word_t'($signed(a) >>> shamt);
            SLT:  return ($signed(a) < $signed(b)) ? one : '0;
            SLTU: return (a < b) ? one : '0;
            XOR:  return a ^ b;
            OR:   return a | b;
            AND:  return a & b;
            default: return a - b;  // SUB and the branches.
        endcase
    endfunction

    function automatic logic model_zero(word_t a, word_t b, alu_op_e op);
        case (op)
            BEQ:  return a == b;
            BNE:  return a != b;
            BLT:  return $signed(a) < $signed(b);
            BGE:  return $signed(a) >= $signed(b);
            BLTU: return a < b;
            BGEU: return a >= b;
            default: return model_result(a, b, op) == '0;
        endcase
    endfunction

    // ####################
    // Checks
    // ####################

    task automatic report_mismatch(string name, word_t got, word_t expected);
        $display("Fail %s: got 0x%h, expected 0x%h", name, got, expected);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    result_check: assert property (@(posedge clk) disable iff (rst)
        result == model_result(data_a, data_b, alu_op))
    else report_mismatch("result", $sampled(result),
        model_result($sampled(data_a), $sampled(data_b), $sampled(alu_op)));

    zero_check: assert property (@(posedge clk) disable iff (rst)
        zero == model_zero(data_a, data_b, alu_op))
    else report_mismatch("zero", word_t'($sampled(zero)),
        word_t'(model_zero($sampled(data_a), $sampled(data_b), $sampled(alu_op))));

    // Set-less-than gives a single bit.
    slt_upper_check: assert property (@(posedge clk) disable iff (rst)
        (alu_op == SLT || alu_op == SLTU) |-> result[width-1:1] == '0)
    else report_mismatch("result[31:1]", $sampled(result) >> 1, '0);

    branch_diff_check: assert property (@(posedge clk) disable iff (rst)
        is_branch(alu_op) |-> result == data_a - data_b)
    else report_mismatch("result", $sampled(result),
        $sampled(data_a) - $sampled(data_b));

    zero_flag_check: assert property (@(posedge clk) disable iff (rst)
        !is_branch(alu_op) |-> zero == (model_result(data_a, data_b, alu_op) == '0))
    else report_mismatch("zero", word_t'($sampled(zero)),
        word_t'(model_result($sampled(data_a), $sampled(data_b),
                             $sampled(alu_op)) == '0));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("Timeout: test did not finish within %0d cycles.", max_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "Simulation stopped by the cycle limit.");
        end
    end

    // ####################
    // Stimulus
    // ####################

    task automatic apply(word_t a, word_t b, alu_op_e op);
        @(posedge clk);
        data_a <= a;
        data_b <= b;
        alu_op <= op;
    endtask

    function automatic word_t rand_word();
        return word_t'($urandom());
    endfunction

    task automatic add_sub_vectors();
        apply(all_ones, one, ADD);  // Wraps to zero.
        apply('0, one, SUB);        // Wraps to all ones.
        for (int i = 0; i < 40; i++) begin
            apply(rand_word(), rand_word(), ADD);
            apply(rand_word(), rand_word(), SUB);
        end
    endtask

    // Upper bits of B are random, the low bits hold the amount.
    task automatic shift_vector(word_t a, int amount, alu_op_e op);
        word_t b;
        b = rand_word();
        b[shamt_width-1:0] = amount[shamt_width-1:0];
        apply(a, b, op);
    endtask

    task automatic shift_vectors(alu_op_e op);
        word_t neg;
        neg = rand_word();
        neg[width-1] = 1'b1;
        shift_vector(rand_word(), 0, op);
        shift_vector(neg, width - 1, op);
        shift_vector(neg, $urandom_range(width - 1, 1), op);
        for (int i = 0; i < 20; i++) begin
            shift_vector(rand_word(), $urandom_range(width - 1, 0), op);
        end
    endtask

    task automatic set_less_vectors(alu_op_e op);
        apply(all_ones, one, op);  // Signed and unsigned disagree.
        apply(one, all_ones, op);
        apply(min_neg, max_pos, op);
        apply(max_pos, min_neg, op);
        for (int i = 0; i < 20; i++) begin
            apply(rand_word(), rand_word(), op);
        end
    endtask

    task automatic logic_vectors(alu_op_e op);
        apply(all_ones, rand_word(), op);
        apply(all_ones, all_ones, op);
        for (int i = 0; i < 15; i++) begin
            apply(rand_word(), rand_word(), op);
        end
    endtask

    task automatic branch_vectors(alu_op_e op);
        word_t r;
        r = rand_word();
        apply(r, r, op);
        apply('0, '0, op);
        apply(min_neg, max_pos, op);
        apply(max_pos, min_neg, op);
        apply(all_ones, one, op);
        apply(one, all_ones, op);
        for (int i = 0; i < 10; i++) begin
            apply(rand_word(), rand_word(), op);
        end
    endtask

    task automatic zero_flag_vectors();
        word_t r;
        r = rand_word();
        apply(r, r, XOR);
        apply(r, r, SUB);
        apply(r, '0, AND);
        apply('0, '0, OR);
        apply(r, -r, ADD);
        apply(min_neg, one, SLL);  // Only set bit shifts out.
        apply(r, r | one, XOR);
        for (int i = 0; i < 50; i++) begin
            r = rand_word();
            apply(r, ($urandom_range(3, 0) == 0) ? r : rand_word(),
                  alu_op_e'($urandom_range(15, 0)));
        end
    endtask

    initial begin
        void'($urandom(32'h923e9a71));
        rst    = 1'b1;
        data_a = '0;
        data_b = '0;
        alu_op = ADD;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        add_sub_vectors();
        shift_vectors(SLL);
        shift_vectors(SRL);
        shift_vectors(SRA);
        set_less_vectors(SLT);
        set_less_vectors(SLTU);
        logic_vectors(XOR);
        logic_vectors(OR);
        logic_vectors(AND);
        branch_vectors(BEQ);
        branch_vectors(BNE);
        branch_vectors(BLT);
        branch_vectors(BGE);
        branch_vectors(BLTU);
        branch_vectors(BGEU);
        zero_flag_vectors();

        @(posedge clk);  // Last vector is sampled here.
        @(negedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule
